/* dv/aes_cases.txt */
# key plaintext expected_ciphertext pause
# Blocks are 128-bit hex; pause is the cycles req stays high after ack.
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32 2
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a 0
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 3
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97 1
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf 0
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688 4
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4 0
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e 5
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34 0

/* sources.f */
+incdir+design
design/aes_pkg.sv
design/aes_job_if.sv
design/aes_sbox.sv
design/aes_key_round.sv
design/aes_cipher_round.sv
design/aes_req_link.sv
design/aes_round_engine.sv
design/aes_top.sv
dv/aes_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= aes_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/aes_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aes_tb import aes_pkg::*; ();

	localparam string CASE_FILE = "dv/aes_cases.txt";
	localparam int MAX_CASES = 32;
	localparam int TIMEOUT = 100; // Cycles allowed for any wait on ack.
	localparam int LATENCY = 12; // Edges from req sampled high to ack high.
	localparam int SEED = 30;

	logic clk;
	logic reset;
	logic req;
	logic [`AES_BLOCK_W-1:0] key;
	logic [`AES_BLOCK_W-1:0] plaintext;
	logic ack;
	logic [`AES_BLOCK_W-1:0] ciphertext;

	aes_block_u case_key [MAX_CASES];
	aes_block_u case_plain [MAX_CASES];
	aes_block_u case_cipher [MAX_CASES];
	int case_pause [MAX_CASES]; // Cycles req stays high after ack.
	int n_cases;
	int n_errors;
	int n_tests;
	int n_failed;
	bit aborted; // Set when a wait ran out of time.

	aes_top i_aes_top (
		.clk(clk),
		.reset(reset),
		.req(req),
		.key(key),
		.plaintext(plaintext),
		.ack(ack),
		.ciphertext(ciphertext)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Compare tasks.
	//////////////////////////////////////////////////

	task automatic check_block(input string name, input aes_block_u got, input aes_block_u exp);
		if (got.word !== exp.word) begin
			$display("ERR %s: got %h, expected %h", name, got.word, exp.word);
			n_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERR %s: got %0h, expected %0h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic finish_test(input string label, input int errs_before);
		if (n_errors == errs_before) begin
			$display("%s: ok", label);
		end else begin
			$display("%s: failed", label);
			n_failed++;
		end
	endtask

	// Lines starting with # are comments.
	task automatic load_cases();
		int fd;
		int fields;
		int pause;
		string line;
		logic [`AES_BLOCK_W-1:0] k;
		logic [`AES_BLOCK_W-1:0] p;
		logic [`AES_BLOCK_W-1:0] c;
		n_cases = 0;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the case file %s", CASE_FILE);
			n_errors++;
			aborted = 1'b1;
			return;
		end
		while (!$feof(fd) && n_cases < MAX_CASES) begin
			if ($fgets(line, fd) == 0) break;
			if (line.len() == 0 || line[0] == "#") continue;
			fields = $sscanf(line, "%h %h %h %d", k, p, c, pause);
			if (fields == 4) begin
				case_key[n_cases].word = k;
				case_plain[n_cases].word = p;
				case_cipher[n_cases].word = c;
				case_pause[n_cases] = pause;
				n_cases++;
			end
		end
		$fclose(fd);
		if (n_cases == 0) begin
			$display("No cases were found in %s", CASE_FILE);
			n_errors++;
			aborted = 1'b1;
		end
	endtask

	// Samples 1 ns after each edge until ack reaches the level.
	task automatic wait_ack(input logic level, output int cycles, output bit ok);
		cycles = 0;
		while (ack !== level && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		ok = (ack === level);
	endtask

	//////////////////////////////////////////////////
	// Jobs.
	//////////////////////////////////////////////////

	task automatic run_job(input int idx, input string tag);
		int cycles;
		int errs_before;
		bit ok;
		string label;
		aes_block_u got;
		aes_block_u held;
		errs_before = n_errors;
		label = $sformatf("case %0d (%s)", idx, tag);
		n_tests++;
		key = case_key[idx].word;
		plaintext = case_plain[idx].word;
		req = 1'b1;
		@(posedge clk); // Edge that samples req high.
		#1;
		wait_ack(1'b1, cycles, ok);
		if (!ok) begin
			$display("%s: ack did not rise within %0d cycles", label, TIMEOUT);
			n_errors++;
			aborted = 1'b1;
		end else begin
			check_count("ack latency", cycles, LATENCY);
			got.word = ciphertext;
			check_block("ciphertext", got, case_cipher[idx]);
			held = got;
			repeat (case_pause[idx]) begin // Requester keeps req high.
				@(posedge clk);
				#1;
				check_bit("ack", ack, 1'b1);
				got.word = ciphertext;
				check_block("ciphertext", got, held);
			end
		end
		req = 1'b0;
		if (ok) begin
			wait_ack(1'b0, cycles, ok);
			if (!ok) begin
				$display("%s: ack did not fall within %0d cycles", label, TIMEOUT);
				n_errors++;
				aborted = 1'b1;
			end else begin
				check_count("ack release", cycles, 1); // First edge with req low.
			end
		end
		finish_test(label, errs_before);
	endtask

	task automatic reset_mid_job(input int idx);
		int errs_before;
		errs_before = n_errors;
		n_tests++;
		key = case_key[idx].word;
		plaintext = case_plain[idx].word;
		req = 1'b1;
		repeat (6) @(posedge clk); // Engine is halfway through its rounds.
		#1;
		reset = 1'b1;
		req = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		check_bit("ack", ack, 1'b0);
		repeat (LATENCY) begin // Covers the edge that would have acked the lost job.
			@(posedge clk);
			#1;
			check_bit("ack", ack, 1'b0);
		end
		finish_test($sformatf("reset in job, case %0d", idx), errs_before);
	endtask

	//////////////////////////////////////////////////
	// Sequence.
	//////////////////////////////////////////////////

	initial begin
		int gap;
		string tag;
		void'($urandom(SEED));
		n_errors = 0;
		n_tests = 0;
		n_failed = 0;
		aborted = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		key = '0;
		plaintext = '0;
		load_cases();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int pass = 0; pass < 2 && !aborted; pass++) begin
			if (pass == 0) begin
				tag = "random gap";
			end else begin
				tag = "back-to-back";
			end
			for (int i = 0; i < n_cases && !aborted; i++) begin
				run_job(i, tag);
				gap = 0;
				if (pass == 0) begin
					gap = int'($urandom % 4);
				end
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
			end
		end
		if (!aborted) begin
			reset_mid_job(0);
		end
		if (!aborted) begin
			run_job(1 % n_cases, "after reset");
		end
		$display("%0d tests, %0d failed, %0d check errors", n_tests, n_failed, n_errors);
		if (n_errors == 0 && !aborted) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/aes_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aes_top (
	input logic clk,
	input logic reset,
	input logic req,
	input logic [`AES_BLOCK_W-1:0] key,
	input logic [`AES_BLOCK_W-1:0] plaintext,
	output logic ack,
	output logic [`AES_BLOCK_W-1:0] ciphertext
);

	aes_job_if job ();

	//////////////////////////////////////////////////
	// Handshake endpoint and iterative engine.
	//////////////////////////////////////////////////

	aes_req_link i_link (
		.clk(clk),
		.reset(reset),
		.req(req),
		.key(key),
		.plaintext(plaintext),
		.ack(ack),
		.ciphertext(ciphertext),
		.job(job.link)
	);

	aes_round_engine i_engine (
		.clk(clk),
		.reset(reset),
		.job(job.engine)
	);

endmodule

`default_nettype wire

/* design/aes_round_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aes_round_engine import aes_pkg::*; (
	input logic clk,
	input logic reset,
	aes_job_if.engine job
);

	aes_block_u state_q; // Cipher state.
	aes_block_u key_q; // Round key of the previous round.
	aes_byte_t rcon_q; // Round constant for the next key.
	logic [3:0] round_q; // Round about to be computed.
	logic busy_q;

	aes_block_u next_key;
	aes_byte_t next_rcon;
	aes_block_u next_state;
	logic final_round;

	assign final_round = (round_q == `AES_NROUND);

	//////////////////////////////////////////////////
	// Round datapath, one round per clock.
	//////////////////////////////////////////////////

	aes_key_round i_key_round (
		.key(key_q),
		.rcon(rcon_q),
		.next_key(next_key),
		.next_rcon(next_rcon)
	);

	aes_cipher_round i_cipher_round (
		.state(state_q),
		.round_key(next_key), // Key is expanded in the same cycle.
		.final_round(final_round),
		.next_state(next_state)
	);

	//////////////////////////////////////////////////
	// Round sequencing.
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			round_q <= '0;
			job.done <= 1'b0;
		end else begin
			job.done <= 1'b0;
			if (job.start) begin
				busy_q <= 1'b1;
				round_q <= 4'd1;
			end else if (busy_q) begin
				round_q <= round_q + 4'd1;
				if (final_round) begin // Tenth round written this edge.
					busy_q <= 1'b0;
					round_q <= '0;
					job.done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (job.start) begin
			state_q.word <= job.plain.word ^ job.key.word; // Initial AddRoundKey.
			key_q <= job.key;
			rcon_q <= 8'h01;
		end else if (busy_q) begin
			state_q <= next_state;
			key_q <= next_key;
			rcon_q <= next_rcon;
		end
	end

	assign job.cipher = state_q; // Final state once done pulses.

endmodule

`default_nettype wire

/* design/aes_req_link.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aes_req_link (
	input logic clk,
	input logic reset,
	input logic req,
	input logic [`AES_BLOCK_W-1:0] key,
	input logic [`AES_BLOCK_W-1:0] plaintext,
	output logic ack,
	output logic [`AES_BLOCK_W-1:0] ciphertext,
	aes_job_if.link job
);

	typedef enum logic [1:0] {
		LINK_IDLE,
		LINK_BUSY,
		LINK_ACKED
	} link_state_e;

	link_state_e state_q;

	//////////////////////////////////////////////////
	// Four-phase handshake controller.
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= LINK_IDLE;
			job.start <= 1'b0;
			ack <= 1'b0;
		end else begin
			job.start <= 1'b0; // Pulse only.
			case (state_q)
				LINK_IDLE: if (req) begin
					job.start <= 1'b1;
					state_q <= LINK_BUSY;
				end
				LINK_BUSY: if (job.done) begin
					ack <= 1'b1;
					state_q <= LINK_ACKED;
				end
				LINK_ACKED: if (!req) begin // Held req keeps ack up.
					ack <= 1'b0;
					state_q <= LINK_IDLE;
				end
				default: state_q <= LINK_IDLE;
			endcase
		end
	end

	// Job payload and the result seen by the requester.
	always_ff @(posedge clk) begin
		if (state_q == LINK_IDLE && req) begin
			job.key.word <= key;
			job.plain.word <= plaintext;
		end
		if (state_q == LINK_BUSY && job.done) begin
			ciphertext <= job.cipher.word; // Stable while ack is high.
		end
	end

endmodule

`default_nettype wire

/* design/aes_cipher_round.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aes_cipher_round import aes_pkg::*; (
	input aes_block_u state,
	input aes_block_u round_key,
	input logic final_round,
	output aes_block_u next_state
);

	aes_byte_t shift_b [0:`AES_NCOL-1][0:3]; // After SubBytes and ShiftRows.

	// MixColumns on a single column.
	function automatic aes_col_t mix_col(input aes_col_t a);
		aes_col_t b;
		b[0] = aes_xtime(a[0]) ^ aes_xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
		b[1] = a[0] ^ aes_xtime(a[1]) ^ aes_xtime(a[2]) ^ a[2] ^ a[3];
		b[2] = a[0] ^ a[1] ^ aes_xtime(a[2]) ^ aes_xtime(a[3]) ^ a[3];
		b[3] = aes_xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ aes_xtime(a[3]);
		return b;
	endfunction

	//////////////////////////////////////////////////
	// SubBytes and ShiftRows.
	//////////////////////////////////////////////////

	// SubBytes works byte by byte, so the row shift is done on the
	// S-box inputs. Row r of column c takes the byte of column c+r.
	for (genvar c = 0; c < `AES_NCOL; c++) begin : g_col
		for (genvar r = 0; r < 4; r++) begin : g_row
			aes_sbox i_sbox (
				.in(state.col[(c + r) % `AES_NCOL][r]),
				.out(shift_b[c][r])
			);
		end
	end

	//////////////////////////////////////////////////
	// MixColumns and AddRoundKey.
	//////////////////////////////////////////////////

	always_comb begin
		for (int c = 0; c < `AES_NCOL; c++) begin
			aes_col_t sr_col;
			aes_col_t mixed;
			sr_col = {shift_b[c][0], shift_b[c][1], shift_b[c][2], shift_b[c][3]};
			mixed = final_round ? sr_col : mix_col(sr_col); // Last round skips the mix.
			next_state.col[c] = mixed ^ round_key.col[c];
		end
	end

endmodule

`default_nettype wire

/* design/aes_key_round.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aes_key_round import aes_pkg::*; (
	input aes_block_u key,
	input aes_byte_t rcon,
	output aes_block_u next_key,
	output aes_byte_t next_rcon
);

	aes_col_t rot_col; // RotWord of the last column.
	aes_byte_t sub_b [0:3]; // SubWord result, one byte per row.
	aes_col_t sub_word; // SubWord with rcon folded in.

	assign rot_col = {key.col[`AES_NCOL-1][1], key.col[`AES_NCOL-1][2],
		key.col[`AES_NCOL-1][3], key.col[`AES_NCOL-1][0]};

	for (genvar r = 0; r < 4; r++) begin : g_sub
		aes_sbox i_sbox (
			.in(rot_col[r]),
			.out(sub_b[r])
		);
	end

	assign sub_word = {sub_b[0] ^ rcon, sub_b[1], sub_b[2], sub_b[3]};

	//////////////////////////////////////////////////
	// Column chain, most significant column first.
	//////////////////////////////////////////////////

	always_comb begin
		next_key.col[0] = key.col[0] ^ sub_word;
		for (int c = 1; c < `AES_NCOL; c++) begin
			next_key.col[c] = key.col[c] ^ next_key.col[c-1];
		end
	end

	// Rcon doubles each round, 01 through 36.
	assign next_rcon = aes_xtime(rcon);

endmodule

`default_nettype wire

/* design/aes_sbox.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_sbox import aes_pkg::*; (
	input aes_byte_t in,
	output aes_byte_t out
);

	logic [127:0] row; // Sixteen entries, entry 0 in the top byte.

	// Upper nibble picks the row, lower nibble the entry.
	always_comb begin
		case (in[7:4])
			4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
			4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
			4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
			4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
			4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
			4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
			4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
			4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
			4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
			4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
			4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
			4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
			4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
			4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
			4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
			default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
		endcase
	end

	// Entry n starts at bit 8*(15-n), which is the inverted nibble times 8.
	assign out = row[{~in[3:0], 3'b000} +: 8];

endmodule

`default_nettype wire

/* design/aes_job_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface aes_job_if import aes_pkg::*; ();

	logic start; // One-cycle pulse, engine idle.
	aes_block_u key; // Cipher key of the job.
	aes_block_u plain; // Plaintext block.
	logic done; // One-cycle pulse, cipher valid.
	aes_block_u cipher; // Ciphertext, valid with done.

	modport link (
		output start,
		output key,
		output plain,
		input done,
		input cipher
	);

	modport engine (
		input start,
		input key,
		input plain,
		output done,
		output cipher
	);

endinterface

`default_nettype wire

/* design/aes_pkg.sv */
`default_nettype none

`include "aes_params.svh"

package aes_pkg;

	typedef logic [7:0] aes_byte_t;

	// Row 0 sits in the top byte of a column.
	typedef aes_byte_t [0:3] aes_col_t;

	// Column 0 is the most significant word of the block.
	typedef union packed {
		logic [`AES_BLOCK_W-1:0] word; // Flat view for ports.
		aes_col_t [0:`AES_NCOL-1] col; // Column view for rounds.
	} aes_block_u;

	// Multiply by x in GF(2^8) with the AES polynomial.
	function automatic aes_byte_t aes_xtime(input aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

/* design/aes_params.svh */
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

//////////////////////////////////////////////////
// AES-128 geometry.
//////////////////////////////////////////////////

`define AES_BLOCK_W 128 // Bits in a block and in a key.
`define AES_NCOL 4 // 32-bit columns per block.
`define AES_NROUND 10 // Cipher rounds after the initial key add.

`endif
